// ==== hw/bus_setup_pkg.sv ====
`default_nettype none

package bus_setup_pkg;

    localparam int data_width = 16;          // bus word
    localparam int master_count = 2;
    localparam int slave_count = 3;

    // depth of slave 1, 2 and 3
    localparam int slave_depths [slave_count] = '{4096, 4096, 2048};
    localparam int master_addr_width = 12;   // covers the deepest slave

    localparam int bank_depth = 16;          // external write entries per master
    localparam int bank_addr_width = 4;

    localparam int cfg_clk_count = 2;        // clocks each config word is held

    typedef logic [1:0] slave_id_t;          // 0 = no slave, 1..3 = slave number

    typedef enum logic [3:0] {
        master_slave_sel,
        read_write_sel,
        external_write_sel,
        external_write_m1,
        external_write_m1_2,
        external_write_m2,
        slave_addr_sel_m1,
        slave_addr_sel_m2,
        addr_count_sel_m1,
        addr_count_sel_m2,
        config_masters,
        communication_ready,
        communicating,
        communication_done
    } main_state_t;

    typedef enum logic [1:0] {
        cfg_start,
        cfg_middle,
        cfg_last,
        cfg_done
    } cfg_state_t;

endpackage

`default_nettype wire

// ==== hw/setup_ifs.sv ====
`timescale 1ns/100ps
`default_nettype none

// four-phase hand-off between the menu FSM and the config streamer
interface cfg_if;
    logic req;
    logic ack;
    logic done_all;   // every master has been streamed

    modport ctrl (
        output req,
        input  ack,
        input  done_all
    );

    modport streamer (
        input  req,
        output ack,
        output done_all
    );
endinterface

// external write data bank, written by the menu and read by the streamer
interface bank_if
    import bus_setup_pkg::*;
();
    logic                                           we;
    logic [$clog2(master_count)-1:0]                wr_master;
    logic                                           advance;
    logic                                           rewind;
    logic [bank_addr_width-1:0]                     ptr;
    logic [master_count-1:0][bank_addr_width-1:0]   wr_count;
    logic [$clog2(master_count)-1:0]                rd_master;
    logic [bank_addr_width-1:0]                     rd_index;
    logic [data_width-1:0]                          rd_data;

    modport ctrl (output we, wr_master, advance, rewind, input ptr);
    modport bank (
        input  we, wr_master, advance, rewind, rd_master, rd_index,
        output ptr, wr_count, rd_data
    );
    modport reader (output rd_master, rd_index, input rd_data, wr_count);
endinterface

`default_nettype wire

// ==== hw/setup_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module setup_ctrl import bus_setup_pkg::*; (
    input  logic                                    clk,
    input  logic                                    rstN,
    input  logic                                    step_n,
    input  logic                                    next_addr_n,
    input  logic [17:0]                             sw,
    input  logic [master_count-1:0]                 m_done,
    input  logic [master_count-1:0][data_width-1:0] m_data_out,
    bank_if.ctrl                                    bank,
    cfg_if.ctrl                                     cfg,
    output main_state_t                             state,
    output logic [master_count-1:0]                 m_eoc,
    output logic [3:0]                              led_state,
    output logic [master_count-1:0]                 run_start,
    output logic [master_addr_width-1:0]            readback_addr,
    output logic [master_count-1:0][data_width-1:0] read_data
);

    main_state_t next_state;
    logic        step;
    logic        next_addr;
    logic        ext_state;

    assign step = ~step_n;           // buttons are active low
    assign next_addr = ~next_addr_n;
    assign ext_state = state inside {external_write_m1, external_write_m1_2, external_write_m2};

    always_comb begin
        next_state = state;
        case (state)
            master_slave_sel: begin
                if (step) begin
                    // no slave picked for either master, nothing to run
                    next_state = (sw[3:0] == '0) ? communication_done : read_write_sel;
                end
            end
            read_write_sel: begin
                if (step) next_state = external_write_sel;
            end
            external_write_sel: begin
                if (step) begin
                    case (sw[1:0])
                        2'b01:   next_state = external_write_m1;
                        2'b10:   next_state = external_write_m2;
                        2'b11:   next_state = external_write_m1_2;
                        default: next_state = slave_addr_sel_m1;
                    endcase
                end
            end
            external_write_m1:   if (step) next_state = slave_addr_sel_m1;
            external_write_m1_2: if (step) next_state = external_write_m2;  // m2 bank next
            external_write_m2:   if (step) next_state = slave_addr_sel_m1;
            slave_addr_sel_m1:   if (step) next_state = slave_addr_sel_m2;
            slave_addr_sel_m2:   if (step) next_state = addr_count_sel_m1;
            addr_count_sel_m1:   if (step) next_state = addr_count_sel_m2;
            addr_count_sel_m2:   if (step) next_state = config_masters;
            config_masters:      if (cfg.ack) next_state = communication_ready;
            communication_ready: begin
                if (step && cfg.done_all) next_state = communicating;
            end
            communicating:       if (&m_done) next_state = communication_done;
            default:             next_state = state;  // communication_done holds until reset
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= master_slave_sel;
            m_eoc <= '0;
            run_start <= '0;
            cfg.req <= 1'b0;
            readback_addr <= '0;
            read_data <= '0;
        end else begin
            state <= next_state;
            if (state == master_slave_sel && step && sw[3:0] == '0) begin
                m_eoc <= '1;                 // tell both masters to skip straight to the end
            end
            run_start <= {master_count{state == communication_ready && step && cfg.done_all}};
            if (cfg.ack) begin
                cfg.req <= 1'b0;
            end else if (state == addr_count_sel_m2 && step) begin
                cfg.req <= 1'b1;
            end
            if (state == communication_done) begin
                read_data <= m_data_out;
                if (next_addr) readback_addr <= sw[master_addr_width-1:0];
            end
        end
    end

    // bank writes follow the switches for as long as an external write state is shown
    always_comb begin
        bank.we = ext_state;
        bank.wr_master = (state == external_write_m2) ? 1'b1 : 1'b0;
        bank.rewind = ext_state && step;  // next bank starts from entry 0
        bank.advance = ext_state && next_addr && !step && (int'(bank.ptr) != bank_depth - 1);
    end

    assign led_state[0] = (state == master_slave_sel);
    assign led_state[1] = (state == communication_ready);
    assign led_state[2] = (state == communication_done);
    assign led_state[3] = (state == communicating);

endmodule

`default_nettype wire

// ==== hw/write_bank.sv ====
`timescale 1ns/100ps
`default_nettype none

module write_bank import bus_setup_pkg::*; (
    input  logic                  clk,
    input  logic                  rstN,
    bank_if.bank                  bank,
    input  logic [data_width-1:0] sw_data
);

    logic [data_width-1:0] mem [master_count][bank_depth];

    // entry under the pointer keeps tracking the switches until the pointer moves on
    always_ff @(posedge clk) begin
        if (bank.we) begin
            mem[bank.wr_master][bank.ptr] <= sw_data;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bank.ptr <= '0;
            bank.wr_count <= '0;
        end else begin
            if (bank.rewind) begin
                bank.ptr <= '0;
            end else if (bank.advance) begin
                bank.ptr <= bank.ptr + 1'b1;
                // a nonzero count also marks the master as burst
                bank.wr_count[bank.wr_master] <= bank.wr_count[bank.wr_master] + 1'b1;
            end
        end
    end

    assign bank.rd_data = mem[bank.rd_master][bank.rd_index];  // combinational read

endmodule

`default_nettype wire

// ==== hw/transfer_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module transfer_regs import bus_setup_pkg::*; (
    input  logic                                           clk,
    input  logic                                           rstN,
    input  main_state_t                                    state,
    input  logic [17:0]                                    sw,
    output slave_id_t [master_count-1:0]                   slave_id,
    output logic [master_count-1:0]                        rd_wr,
    output logic [master_count-1:0]                        ext_sel,
    output logic [master_count-1:0][master_addr_width-1:0] first_addr,
    output logic [master_count-1:0][master_addr_width:0]   last_addr
);

    // start plus count, held at the slave depth when it runs past the end
    function automatic logic [master_addr_width:0] clamp_last(
        input logic [master_addr_width-1:0] start,
        input logic [master_addr_width-1:0] count,
        input slave_id_t                    id
    );
        logic [master_addr_width:0] sum;
        int                         depth;
        sum = {1'b0, start} + {1'b0, count};
        depth = (id == '0) ? slave_depths[0] : slave_depths[int'(id) - 1];
        if (int'(sum) >= depth) begin
            return (master_addr_width + 1)'(depth);
        end
        return sum;
    endfunction

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            slave_id <= '0;
            rd_wr <= '0;
            ext_sel <= '0;
            first_addr <= '0;
            last_addr <= '0;
        end else begin
            case (state)
                master_slave_sel: begin
                    for (int k = 0; k < master_count; k++) begin
                        slave_id[k] <= sw[2*k +: 2];   // two bits per master
                    end
                end
                read_write_sel:     rd_wr <= sw[master_count-1:0];
                external_write_sel: ext_sel <= sw[master_count-1:0];
                slave_addr_sel_m1:  first_addr[0] <= sw[master_addr_width-1:0];
                slave_addr_sel_m2:  first_addr[1] <= sw[master_addr_width-1:0];
                addr_count_sel_m1: begin
                    last_addr[0] <= clamp_last(first_addr[0], sw[master_addr_width-1:0],
                                               slave_id[0]);
                end
                addr_count_sel_m2: begin
                    last_addr[1] <= clamp_last(first_addr[1], sw[master_addr_width-1:0],
                                               slave_id[1]);
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/config_streamer.sv ====
`timescale 1ns/100ps
`default_nettype none

module config_streamer import bus_setup_pkg::*; (
    input  logic                                           clk,
    input  logic                                           rstN,
    cfg_if.streamer                                        cfg,
    bank_if.reader                                         bank,
    input  logic [master_count-1:0]                        ext_sel,
    input  logic [master_count-1:0][master_addr_width-1:0] first_addr,
    output logic [master_count-1:0]                        cfg_start,
    output logic [master_count-1:0][master_addr_width-1:0] cfg_address,
    output logic [master_count-1:0][data_width-1:0]        cfg_data
);

    cfg_state_t                         sub_state;
    logic [$clog2(master_count)-1:0]    cur_master;
    logic [bank_addr_width-1:0]         word_idx;
    logic [bank_addr_width-1:0]         last_idx;
    logic [$clog2(cfg_clk_count)-1:0]   hold_cnt;
    logic                               go;
    logic                               hold_end;

    assign go = cfg.req & ~cfg.ack;  // stream runs only inside an open request
    assign hold_end = (int'(hold_cnt) == cfg_clk_count - 1);
    assign last_idx = ext_sel[cur_master] ? bank.wr_count[cur_master] : '0;

    assign bank.rd_master = cur_master;
    assign bank.rd_index = word_idx;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            sub_state <= bus_setup_pkg::cfg_start;
            cur_master <= '0;
            word_idx <= '0;
            hold_cnt <= '0;
            cfg.ack <= 1'b0;
            cfg.done_all <= 1'b0;
        end else begin
            if (cfg.ack && !cfg.req) cfg.ack <= 1'b0;
            if (go) begin
                cfg.done_all <= 1'b0;
                if (sub_state == cfg_done) begin
                    sub_state <= bus_setup_pkg::cfg_start;  // ready for the next request
                    cur_master <= '0;
                    cfg.ack <= 1'b1;
                    cfg.done_all <= 1'b1;
                end else if (!hold_end) begin
                    hold_cnt <= hold_cnt + 1'b1;
                end else begin
                    hold_cnt <= '0;
                    if (word_idx == last_idx) begin
                        word_idx <= '0;
                        if (int'(cur_master) == master_count - 1) begin
                            sub_state <= cfg_done;
                        end else begin
                            cur_master <= cur_master + 1'b1;   // next master, no gap
                            sub_state <= bus_setup_pkg::cfg_start;
                        end
                    end else begin
                        word_idx <= word_idx + 1'b1;
                        sub_state <= (word_idx + 1'b1 == last_idx) ? cfg_last : cfg_middle;
                    end
                end
            end
        end
    end

    // only the master being configured sees address and data
    always_comb begin
        for (int k = 0; k < master_count; k++) begin
            cfg_start[k] = 1'b0;
            cfg_address[k] = '0;
            cfg_data[k] = '0;
            if (go && sub_state != cfg_done && int'(cur_master) == k) begin
                cfg_start[k] = (hold_cnt == '0) &&
                               (sub_state == bus_setup_pkg::cfg_start || sub_state == cfg_last);
                cfg_address[k] = first_addr[k];
                cfg_data[k] = bank.rd_data;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/bus_setup_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module bus_setup_top import bus_setup_pkg::*; (
    input  logic                                           clk,
    input  logic                                           rstN,
    input  logic                                           step_n,
    input  logic                                           next_addr_n,
    input  logic [17:0]                                    sw,
    input  logic [master_count-1:0]                        m_done,
    input  logic [master_count-1:0][data_width-1:0]        m_data_out,
    output logic [master_count-1:0]                        m_start,
    output logic [master_count-1:0][master_addr_width-1:0] m_address,
    output logic [master_count-1:0][data_width-1:0]        m_data,
    output logic [master_count-1:0]                        m_burst,
    output logic [master_count-1:0]                        m_rd_wr,
    output slave_id_t [master_count-1:0]                   m_slave_id,
    output logic [master_count-1:0][master_addr_width:0]   m_last_addr,
    output logic [master_count-1:0]                        m_eoc,
    output logic [3:0]                                     led_state,
    output logic [master_count-1:0][data_width-1:0]        read_data
);

    main_state_t                                    state;
    logic [master_count-1:0]                        stream_start;
    logic [master_count-1:0]                        run_start;
    logic [master_count-1:0]                        ext_sel;
    logic [master_count-1:0][master_addr_width-1:0] first_addr;
    logic [master_count-1:0][master_addr_width-1:0] cfg_address;
    logic [master_addr_width-1:0]                   readback_addr;

    cfg_if  cfg_bus ();
    bank_if bank_bus ();

    setup_ctrl u_ctrl (
        .clk, .rstN, .step_n, .next_addr_n, .sw, .m_done, .m_data_out,
        .bank(bank_bus.ctrl), .cfg(cfg_bus.ctrl),
        .state, .m_eoc, .led_state, .run_start, .readback_addr, .read_data
    );

    write_bank u_bank (
        .clk, .rstN, .bank(bank_bus.bank), .sw_data(sw[data_width-1:0])
    );

    transfer_regs u_regs (
        .clk, .rstN, .state, .sw,
        .slave_id(m_slave_id), .rd_wr(m_rd_wr), .ext_sel,
        .first_addr, .last_addr(m_last_addr)
    );

    config_streamer u_streamer (
        .clk, .rstN, .cfg(cfg_bus.streamer), .bank(bank_bus.reader),
        .ext_sel, .first_addr,
        .cfg_start(stream_start), .cfg_address, .cfg_data(m_data)
    );

    assign m_start = stream_start | run_start;   // config pulses or the run kick-off

    always_comb begin
        for (int k = 0; k < master_count; k++) begin
            // after the run both masters read from the operator's address
            m_address[k] = (state == communication_done) ? readback_addr : cfg_address[k];
            m_burst[k] = |bank_bus.wr_count[k];
        end
    end

endmodule

`default_nettype wire

// ==== testbench/bus_setup_props.sv ====
`timescale 1ns/100ps
`default_nettype none

module bus_setup_props import bus_setup_pkg::*; (
    input logic                                           clk,
    input logic                                           rstN,
    input logic                                           step_n,
    input logic                                           next_addr_n,
    input logic [17:0]                                    sw,
    input logic [master_count-1:0]                        m_done,
    input logic [master_count-1:0]                        m_start,
    input logic [master_count-1:0][master_addr_width-1:0] m_address,
    input logic [master_count-1:0]                        m_eoc,
    input logic [3:0]                                     led_state
);

    int fail_count = 0;

    // first menu state right after reset, nothing pulsed yet
    reset_state: assert property (@(posedge clk)
        $rose(rstN) |-> (led_state == 4'b0001 && m_start == '0 && m_eoc == '0))
        else begin
            $error("menu did not come out of reset in its first state");
            fail_count++;
        end

    eoc_shortcut: assert property (@(posedge clk) disable iff (!rstN)
        (led_state[0] && !step_n && sw[3:0] == 4'h0) |=> (&m_eoc && led_state[2]))
        else begin
            $error("no-slave step did not raise end of communication");
            fail_count++;
        end

    run_start_on: assert property (@(posedge clk) disable iff (!rstN)
        (led_state[1] && !step_n) |=> (m_start == 2'b11))
        else begin
            $error("run start missing on a master");
            fail_count++;
        end

    run_start_once: assert property (@(posedge clk) disable iff (!rstN)
        (led_state[3] && m_start == 2'b11) |=> (m_start == 2'b00))
        else begin
            $error("run start held longer than one cycle");
            fail_count++;
        end

    // stays in communicating until both masters report done
    comm_hold: assert property (@(posedge clk) disable iff (!rstN)
        (led_state[3] && !(&m_done)) |=> led_state[3])
        else begin
            $error("left communicating before both masters were done");
            fail_count++;
        end

    comm_end: assert property (@(posedge clk) disable iff (!rstN)
        (led_state[3] && &m_done) |=> led_state[2])
        else begin
            $error("did not reach communication done after both masters finished");
            fail_count++;
        end

    readback_addr: assert property (@(posedge clk) disable iff (!rstN)
        (led_state[2] && !next_addr_n) |=>
            (m_address[0] == $past(sw[11:0]) && m_address[1] == $past(sw[11:0])))
        else begin
            $error("readback address not loaded from the switches");
            fail_count++;
        end

endmodule

`default_nettype wire

// ==== testbench/tb_bus_setup.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_bus_setup import bus_setup_pkg::*; ();

    localparam int clk_period = 20;
    localparam int reset_cycles = 5;
    localparam logic [31:0] seed = 32'h6ebe_0cec;
    localparam int max_wait = 64;                      // cap on any single wait in cycles
    localparam int menu_cycles = 12 + 2 * bank_depth;  // presses plus bank entries
    localparam int watchdog_cycles = 2 * reset_cycles + menu_cycles + 4 * max_wait;
    localparam int depth_of [master_count] = '{2048, 4096};  // slave 3 on m0, slave 1 on m1

    logic                                           clk;
    logic                                           rstN;
    logic                                           step_n;
    logic                                           next_addr_n;
    logic [17:0]                                    sw;
    logic [master_count-1:0]                        m_done;
    logic [master_count-1:0][data_width-1:0]        m_data_out;
    logic [master_count-1:0]                        m_start;
    logic [master_count-1:0][master_addr_width-1:0] m_address;
    logic [master_count-1:0][data_width-1:0]        m_data;
    logic [master_count-1:0]                        m_burst;
    logic [master_count-1:0]                        m_rd_wr;
    slave_id_t [master_count-1:0]                   m_slave_id;
    logic [master_count-1:0][master_addr_width:0]   m_last_addr;
    logic [master_count-1:0]                        m_eoc;
    logic [3:0]                                     led_state;
    logic [master_count-1:0][data_width-1:0]        read_data;

    int                           errors = 0;
    int                           done_delay [master_count];
    int                           word_count [master_count];
    logic [data_width-1:0]        bank_vals [master_count][bank_depth];
    logic [master_addr_width-1:0] start_addr [master_count];
    logic [master_addr_width-1:0] addr_count [master_count];

    bus_setup_top u_dut (.*);

    bind bus_setup_top bus_setup_props u_props (
        .clk, .rstN, .step_n, .next_addr_n, .sw, .m_done, .m_start, .m_address, .m_eoc,
        .led_state
    );

    // what each master returns for a read at addr
    function automatic logic [data_width-1:0] model_word(input int k,
                                                         input logic [master_addr_width-1:0] addr);
        return {4'(k + 1), addr} ^ 16'h3c5a;
    endfunction

    always_comb begin
        for (int k = 0; k < master_count; k++) m_data_out[k] = model_word(k, m_address[k]);
    end

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic apply_reset();
        rstN = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #2 rstN = 1'b1;
    endtask

    task automatic step_menu();
        step_n = 1'b0;
        @(posedge clk);
        #2 step_n = 1'b1;
    endtask

    task automatic press_next_addr(input logic [data_width-1:0] value);
        sw[data_width-1:0] = value;
        next_addr_n = 1'b0;
        @(posedge clk);
        #2 next_addr_n = 1'b1;
    endtask

    task automatic check_value(input string name, input longint expected, input longint actual);
        assert (expected == actual) else begin
            $display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
            errors++;
        end
    endtask

    // counts falling edges until a state LED lights
    task automatic wait_led(input int led, output int cycles);
        cycles = 0;
        while (!led_state[led] && cycles < max_wait) begin
            @(negedge clk);
            cycles++;
        end
        if (!led_state[led]) begin
            $display("state LED %0d did not light within %0d cycles", led, max_wait);
            errors++;
        end
    endtask

    // done comes a set number of cycles after each master's run start
    initial begin : master_model
        int left [master_count];
        m_done = '0;
        left = '{0, 0};
        forever begin
            @(negedge clk);
            for (int k = 0; k < master_count; k++) begin
                if (m_start[k] && led_state[3]) left[k] = done_delay[k];
            end
            @(posedge clk);
            #2;
            for (int k = 0; k < master_count; k++) begin
                if (left[k] > 0) begin
                    left[k]--;
                    if (left[k] == 0) m_done[k] = 1'b1;
                end
            end
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles", watchdog_cycles);
        $display("Something failed");
        $finish;
    end

    initial begin
        int                           lat_cycles;
        int                           words;
        int                           sum;
        logic [master_count-1:0]      exp_start;
        logic [1:0]                   rw;
        logic [master_addr_width-1:0] rb_addr;
        void'($urandom(seed));
        rstN = 1'b0;
        step_n = 1'b1;
        next_addr_n = 1'b1;
        sw = '0;
        apply_reset();

        step_menu();  // no slave on either master
        @(negedge clk);
        check_value("eoc_shortcut", 2'b11, m_eoc);
        check_value("eoc_led", 4'b0100, led_state);
        @(posedge clk);
        #2;
        apply_reset();

        sw = 18'h0007;  // m0 on slave 3, m1 on slave 1
        step_menu();
        rw = 2'($urandom_range(3, 0));
        sw = {16'h0, rw};
        step_menu();
        sw = 18'h0003;  // external write on both
        step_menu();
        word_count = '{4, 2};
        for (int k = 0; k < master_count; k++) begin
            for (int j = 0; j < word_count[k]; j++) begin
                bank_vals[k][j] = 16'($urandom());
                if (j < word_count[k] - 1) begin
                    press_next_addr(bank_vals[k][j]);
                end else begin
                    sw[data_width-1:0] = bank_vals[k][j];  // kept by the step
                    step_menu();
                end
            end
        end
        start_addr[0] = 12'(1500 + $urandom_range(499, 0));
        addr_count[0] = 12'(600 + $urandom_range(399, 0));  // runs past 2048
        start_addr[1] = 12'($urandom_range(999, 0));
        addr_count[1] = 12'($urandom_range(999, 0));
        for (int k = 0; k < master_count; k++) begin
            sw = {6'h0, start_addr[k]};
            step_menu();
        end
        for (int k = 0; k < master_count; k++) begin
            sw = {6'h0, addr_count[k]};
            step_menu();
        end

        // config stream starts right after the step edge that raises req
        for (int k = 0; k < master_count; k++) begin
            for (int j = 0; j < word_count[k]; j++) begin
                for (int h = 0; h < cfg_clk_count; h++) begin
                    @(negedge clk);
                    exp_start = '0;
                    exp_start[k] = (h == 0) && (j == 0 || j == word_count[k] - 1);
                    check_value($sformatf("start_m%0d_w%0d", k, j), exp_start, m_start);
                    check_value($sformatf("data_m%0d_w%0d", k, j), bank_vals[k][j], m_data[k]);
                    check_value($sformatf("addr_m%0d", k), start_addr[k], m_address[k]);
                end
            end
        end
        words = word_count[0] + word_count[1];
        wait_led(1, lat_cycles);
        // ack comes 2*words + 1 cycles after req and the state follows one clock later
        check_value("ready_latency", 2 * words + 2, 2 * words + lat_cycles - 1);
        check_value("burst", 2'b11, m_burst);
        check_value("rd_wr", rw, m_rd_wr);
        check_value("slave_id_m0", 3, m_slave_id[0]);
        check_value("slave_id_m1", 1, m_slave_id[1]);
        for (int k = 0; k < master_count; k++) begin
            sum = int'(start_addr[k]) + int'(addr_count[k]);
            check_value($sformatf("last_addr_m%0d", k), (sum >= depth_of[k]) ? depth_of[k] : sum,
                        m_last_addr[k]);
        end

        done_delay[0] = $urandom_range(12, 3);
        done_delay[1] = done_delay[0] + $urandom_range(6, 2);
        @(posedge clk);
        #2;
        step_menu();
        wait_led(2, lat_cycles);
        check_value("done_at_end", 2'b11, m_done);

        @(posedge clk);
        #2;
        rb_addr = 12'($urandom());
        press_next_addr({4'h0, rb_addr});
        @(negedge clk);
        @(negedge clk);  // read data is registered
        for (int k = 0; k < master_count; k++) begin
            check_value($sformatf("readback_m%0d", k), model_word(k, rb_addr), read_data[k]);
        end

        $display("errors: %0d testbench checks, %0d bound assertions", errors,
                 u_dut.u_props.fail_count);
        if (errors == 0 && u_dut.u_props.fail_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
hw/bus_setup_pkg.sv
hw/setup_ifs.sv
hw/setup_ctrl.sv
hw/write_bank.sv
hw/transfer_regs.sv
hw/config_streamer.sv
hw/bus_setup_top.sv
testbench/bus_setup_props.sv
testbench/tb_bus_setup.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_bus_setup -f project.f \
    -o sim_bus_setup > build.log 2>&1 \
    && ./obj_dir/sim_bus_setup +verilator+error+limit+1000 > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "Something failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
